// ==== common/ads868x_defs.svh ====
`ifndef ADS868X_DEFS_SVH
`define ADS868X_DEFS_SVH

// conversion result width of the ADC
`define ADS_DATA_W 16

// analog mux inputs
`define ADS_NUM_CH 8

// sck periods per conversion frame
`define ADS_FRAME_BITS 32

// mux settling time in clocks
`define ADS_SETTLE_CYCLES 16

// reset values of PERIOD and SCK_DIV
`define ADS_PERIOD_RST 4000
`define ADS_SCKDIV_RST 1

`endif

// ==== common/ads868x_pkg.sv ====
`default_nettype none

package ads868x_pkg;

    // scan sequencer states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        SELECT  = 3'd1,
        SETTLE  = 3'd2,
        CONVERT = 3'd3,
        EMIT    = 3'd4
    } seq_state_t;

    // register word offsets on the AXI4-Lite port
    typedef enum logic [7:0] {
        // bit0 enable, bit1 rst_pd_n
        CTRL    = 8'h00,
        // channels 7..0
        CH_MASK = 8'h04,
        // tick interval in clocks
        PERIOD  = 8'h08,
        // sck half-period is value+1 clocks
        SCK_DIV = 8'h0C,
        // busy, overrun count, conversion count
        STATUS  = 8'h10
    } reg_addr_t;

    // AXI response codes in use
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } axi_resp_t;

endpackage

`default_nettype wire

// ==== common/ads868x_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ads868x_defs.svh"

// sequencer to SPI engine conversion handshake
interface adc_xfer_if;
    logic                   start;
    logic                   busy;
    logic                   done;
    logic [`ADS_DATA_W-1:0] result;

    modport seq (output start, input busy, done, result);
    modport spi (input start, output busy, done, result);
endinterface

// sample tick and mux settle timing
interface scan_timer_if;
    logic settle_start;
    logic settle_done;
    logic tick;

    modport tmr (input settle_start, output settle_done, tick);
    modport seq (output settle_start, input settle_done, tick);
endinterface

`default_nettype wire

// ==== verilog/ads868x_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ads868x_defs.svh"

module ads868x_regs (
    input  logic        s_axi_aclk,
    input  logic        arst_n,
    input  logic [31:0] s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,
    output logic [1:0]  s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    input  logic [31:0] s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,
    input  logic        busy,
    input  logic        conv_pulse,
    input  logic        overrun_pulse,
    output logic        enable,
    output logic        rst_pd_n,
    output logic [7:0]  ch_mask,
    output logic [23:0] period,
    output logic [7:0]  sck_div
);

    logic                    wr_en;
    logic                    rd_en;
    ads868x_pkg::axi_resp_t  wr_resp;
    ads868x_pkg::axi_resp_t  rd_resp;
    logic [31:0]             rd_data;
    logic [15:0]             conv_cnt;
    logic [7:0]              ovr_cnt;

    // address and data must arrive together, one write in flight
    assign wr_en = s_axi_awvalid && s_axi_wvalid && !s_axi_bvalid;
    assign rd_en = s_axi_arvalid && !s_axi_rvalid;

    assign s_axi_awready = wr_en;
    assign s_axi_wready  = wr_en;
    assign s_axi_arready = rd_en;

    always_comb begin
        case (s_axi_awaddr[7:0])
            ads868x_pkg::CTRL,
            ads868x_pkg::CH_MASK,
            ads868x_pkg::PERIOD,
            ads868x_pkg::SCK_DIV,
            ads868x_pkg::STATUS:  wr_resp = ads868x_pkg::OKAY;
            default:              wr_resp = ads868x_pkg::SLVERR;
        endcase
    end

    always_comb begin
        rd_data = '0;
        rd_resp = ads868x_pkg::OKAY;
        case (s_axi_araddr[7:0])
            ads868x_pkg::CTRL:    rd_data = {30'd0, rst_pd_n, enable};
            ads868x_pkg::CH_MASK: rd_data = {24'd0, ch_mask};
            ads868x_pkg::PERIOD:  rd_data = {8'd0, period};
            ads868x_pkg::SCK_DIV: rd_data = {24'd0, sck_div};
            ads868x_pkg::STATUS:  rd_data = {conv_cnt, ovr_cnt, 7'd0, busy};
            default:              rd_resp = ads868x_pkg::SLVERR;
        endcase
    end

    // response handshakes
    always_ff @(posedge s_axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            s_axi_bvalid <= 1'b0;
            s_axi_rvalid <= 1'b0;
        end else begin
            if (wr_en)
                s_axi_bvalid <= 1'b1;
            else if (s_axi_bready)
                s_axi_bvalid <= 1'b0;
            if (rd_en)
                s_axi_rvalid <= 1'b1;
            else if (s_axi_rready)
                s_axi_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge s_axi_aclk) begin
        if (wr_en)
            s_axi_bresp <= wr_resp;
        if (rd_en) begin
            s_axi_rdata <= rd_data;
            s_axi_rresp <= rd_resp;
        end
    end

    // writable registers, byte strobes honoured
    always_ff @(posedge s_axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            enable   <= 1'b0;
            rst_pd_n <= 1'b0;
            ch_mask  <= '0;
            period   <= 24'(`ADS_PERIOD_RST);
            sck_div  <= 8'(`ADS_SCKDIV_RST);
        end else if (wr_en && s_axi_wstrb[0]) begin
            case (s_axi_awaddr[7:0])
                ads868x_pkg::CTRL: begin
                    enable   <= s_axi_wdata[0];
                    rst_pd_n <= s_axi_wdata[1];
                end
                ads868x_pkg::CH_MASK: ch_mask      <= s_axi_wdata[7:0];
                ads868x_pkg::PERIOD:  period[7:0]  <= s_axi_wdata[7:0];
                ads868x_pkg::SCK_DIV: sck_div      <= s_axi_wdata[7:0];
                default: ;
            endcase
        end
        // upper period bytes
        if (arst_n && wr_en && s_axi_awaddr[7:0] == ads868x_pkg::PERIOD) begin
            if (s_axi_wstrb[1])
                period[15:8] <= s_axi_wdata[15:8];
            if (s_axi_wstrb[2])
                period[23:16] <= s_axi_wdata[23:16];
        end
    end

    // status counters, conversions wrap and overruns saturate
    always_ff @(posedge s_axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            conv_cnt <= '0;
            ovr_cnt  <= '0;
        end else begin
            if (conv_pulse)
                conv_cnt <= conv_cnt + 16'd1;
            if (overrun_pulse && ovr_cnt != 8'hFF)
                ovr_cnt <= ovr_cnt + 8'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ads868x_seq.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ads868x_defs.svh"

module ads868x_seq (
    input  logic                s_axi_aclk,
    input  logic                arst_n,
    input  logic                enable,
    input  logic [7:0]          ch_mask,
    input  logic                m_axis_tready,
    output logic                busy,
    output logic                conv_pulse,
    output logic                overrun_pulse,
    output logic [2:0]          ch_sel,
    output logic [31:0]         m_axis_tdata,
    output logic                m_axis_tvalid,
    adc_xfer_if.seq             xfer,
    scan_timer_if.seq           tmr
);

    ads868x_pkg::seq_state_t state;
    logic [7:0]              pending;
    logic [2:0]              next_ch;

    assign busy = (state != ads868x_pkg::IDLE);

    // lowest channel still waiting in this scan
    always_comb begin
        next_ch = '0;
        for (int i = `ADS_NUM_CH - 1; i >= 0; i--) begin
            if (pending[i])
                next_ch = 3'(i);
        end
    end

    always_ff @(posedge s_axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            state            <= ads868x_pkg::IDLE;
            pending          <= '0;
            ch_sel           <= '0;
            tmr.settle_start <= 1'b0;
            xfer.start       <= 1'b0;
            m_axis_tvalid    <= 1'b0;
            conv_pulse       <= 1'b0;
            overrun_pulse    <= 1'b0;
        end else begin
            tmr.settle_start <= 1'b0;
            xfer.start       <= 1'b0;
            conv_pulse       <= 1'b0;
            // a tick mid-scan is lost and counted
            overrun_pulse    <= tmr.tick && state != ads868x_pkg::IDLE;
            case (state)
                ads868x_pkg::IDLE: begin
                    if (tmr.tick && enable && ch_mask != '0) begin
                        pending <= ch_mask;
                        state   <= ads868x_pkg::SELECT;
                    end
                end
                ads868x_pkg::SELECT: begin
                    ch_sel           <= next_ch;
                    pending[next_ch] <= 1'b0;
                    tmr.settle_start <= 1'b1;
                    state            <= ads868x_pkg::SETTLE;
                end
                ads868x_pkg::SETTLE: begin
                    if (tmr.settle_done && !xfer.busy) begin
                        xfer.start <= 1'b1;
                        state      <= ads868x_pkg::CONVERT;
                    end
                end
                ads868x_pkg::CONVERT: begin
                    if (xfer.done) begin
                        m_axis_tvalid <= 1'b1;
                        state         <= ads868x_pkg::EMIT;
                    end
                end
                ads868x_pkg::EMIT: begin
                    if (m_axis_tready) begin
                        m_axis_tvalid <= 1'b0;
                        conv_pulse    <= 1'b1;
                        state <= (pending != '0) ? ads868x_pkg::SELECT : ads868x_pkg::IDLE;
                    end
                end
                default: state <= ads868x_pkg::IDLE;
            endcase
        end
    end

    // stream word, channel above the sample
    always_ff @(posedge s_axi_aclk) begin
        if (state == ads868x_pkg::CONVERT && xfer.done)
            m_axis_tdata <= {{(32 - 3 - `ADS_DATA_W){1'b0}}, ch_sel, xfer.result};
    end

endmodule

`default_nettype wire

// ==== verilog/ads868x_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ads868x_defs.svh"

module ads868x_timer (
    input  logic        s_axi_aclk,
    input  logic        arst_n,
    input  logic        enable,
    input  logic [23:0] period,
    scan_timer_if.tmr   tmr
);

    logic [23:0] tick_cnt;
    logic [23:0] period_q;
    logic [4:0]  settle_cnt;

    // sample period ticks, a new PERIOD value restarts the count
    always_ff @(posedge s_axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
            period_q <= '0;
            tmr.tick <= 1'b0;
        end else begin
            period_q <= period;
            if (!enable || period != period_q) begin
                tick_cnt <= '0;
                tmr.tick <= 1'b0;
            end else if ({1'b0, tick_cnt} + 25'd1 >= {1'b0, period}) begin
                tick_cnt <= '0;
                tmr.tick <= 1'b1;
            end else begin
                tick_cnt <= tick_cnt + 24'd1;
                tmr.tick <= 1'b0;
            end
        end
    end

    // settle_done lands ADS_SETTLE_CYCLES after settle_start
    always_ff @(posedge s_axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            settle_cnt      <= '0;
            tmr.settle_done <= 1'b0;
        end else begin
            tmr.settle_done <= (settle_cnt == 5'd1);
            if (tmr.settle_start)
                settle_cnt <= 5'(`ADS_SETTLE_CYCLES - 1);
            else if (settle_cnt != '0)
                settle_cnt <= settle_cnt - 5'd1;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/ads868x_spi.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ads868x_defs.svh"

module ads868x_spi (
    input  logic       s_axi_aclk,
    input  logic       arst_n,
    input  logic [7:0] sck_div,
    input  logic       miso,
    output logic       sck,
    output logic       ss_n,
    output logic       mosi,
    adc_xfer_if.spi    xfer
);

    logic [7:0]                  div_cnt;
    logic [5:0]                  edge_cnt;
    logic                        tail;
    logic [`ADS_FRAME_BITS-1:0]  shreg;

    // first half of the frame is the conversion result
    assign xfer.result = shreg[`ADS_FRAME_BITS-1 -: `ADS_DATA_W];

    always_ff @(posedge s_axi_aclk or negedge arst_n) begin
        if (!arst_n) begin
            xfer.busy <= 1'b0;
            xfer.done <= 1'b0;
            ss_n      <= 1'b1;
            sck       <= 1'b0;
            mosi      <= 1'b0;
            div_cnt   <= '0;
            edge_cnt  <= '0;
            tail      <= 1'b0;
            shreg     <= '0;
        end else begin
            xfer.done <= 1'b0;
            if (!xfer.busy) begin
                if (xfer.start) begin
                    xfer.busy <= 1'b1;
                    ss_n      <= 1'b0;
                    div_cnt   <= sck_div;
                    edge_cnt  <= '0;
                    tail      <= 1'b0;
                    // NOP command, zero word
                    shreg     <= '0;
                    mosi      <= 1'b0;
                end
            end else if (div_cnt != '0) begin
                div_cnt <= div_cnt - 8'd1;
            end else begin
                div_cnt <= sck_div;
                if (tail) begin
                    // half a period after the last falling edge
                    xfer.busy <= 1'b0;
                    xfer.done <= 1'b1;
                    ss_n      <= 1'b1;
                end else begin
                    sck      <= !sck;
                    edge_cnt <= edge_cnt + 6'd1;
                    if (!sck) begin
                        // rising edge samples the ADC
                        shreg <= {shreg[`ADS_FRAME_BITS-2:0], miso};
                    end else if (edge_cnt == 6'(2 * `ADS_FRAME_BITS - 1)) begin
                        mosi <= 1'b0;
                        tail <= 1'b1;
                    end else begin
                        mosi <= shreg[`ADS_FRAME_BITS-1];
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/axi_ads868x.sv ====
`timescale 1ns/100ps
`default_nettype none

module axi_ads868x (
    input  logic        s_axi_aclk,
    input  logic        arst_n,
    // AXI4-Lite slave
    input  logic [31:0] s_axi_awaddr,
    input  logic        s_axi_awvalid,
    output logic        s_axi_awready,
    input  logic [31:0] s_axi_wdata,
    input  logic [3:0]  s_axi_wstrb,
    input  logic        s_axi_wvalid,
    output logic        s_axi_wready,
    output logic [1:0]  s_axi_bresp,
    output logic        s_axi_bvalid,
    input  logic        s_axi_bready,
    input  logic [31:0] s_axi_araddr,
    input  logic        s_axi_arvalid,
    output logic        s_axi_arready,
    output logic [31:0] s_axi_rdata,
    output logic [1:0]  s_axi_rresp,
    output logic        s_axi_rvalid,
    input  logic        s_axi_rready,
    // sample stream
    output logic [31:0] m_axis_tdata,
    output logic        m_axis_tvalid,
    input  logic        m_axis_tready,
    // ADC and mux pins
    output logic        sck,
    output logic        ss_n,
    output logic        mosi,
    input  logic        miso,
    output logic        rst_pd_n,
    output logic [2:0]  ch_sel
);

    logic        enable;
    logic [7:0]  ch_mask;
    logic [23:0] period;
    logic [7:0]  sck_div;
    logic        seq_busy;
    logic        conv_pulse;
    logic        overrun_pulse;

    adc_xfer_if   xfer_if ();
    scan_timer_if tmr_if ();

    ads868x_regs regs_i (
        .s_axi_aclk    (s_axi_aclk),
        .arst_n        (arst_n),
        .s_axi_awaddr  (s_axi_awaddr),
        .s_axi_awvalid (s_axi_awvalid),
        .s_axi_awready (s_axi_awready),
        .s_axi_wdata   (s_axi_wdata),
        .s_axi_wstrb   (s_axi_wstrb),
        .s_axi_wvalid  (s_axi_wvalid),
        .s_axi_wready  (s_axi_wready),
        .s_axi_bresp   (s_axi_bresp),
        .s_axi_bvalid  (s_axi_bvalid),
        .s_axi_bready  (s_axi_bready),
        .s_axi_araddr  (s_axi_araddr),
        .s_axi_arvalid (s_axi_arvalid),
        .s_axi_arready (s_axi_arready),
        .s_axi_rdata   (s_axi_rdata),
        .s_axi_rresp   (s_axi_rresp),
        .s_axi_rvalid  (s_axi_rvalid),
        .s_axi_rready  (s_axi_rready),
        .busy          (seq_busy),
        .conv_pulse    (conv_pulse),
        .overrun_pulse (overrun_pulse),
        .enable        (enable),
        .rst_pd_n      (rst_pd_n),
        .ch_mask       (ch_mask),
        .period        (period),
        .sck_div       (sck_div)
    );

    ads868x_seq seq_i (
        .s_axi_aclk    (s_axi_aclk),
        .arst_n        (arst_n),
        .enable        (enable),
        .ch_mask       (ch_mask),
        .m_axis_tready (m_axis_tready),
        .busy          (seq_busy),
        .conv_pulse    (conv_pulse),
        .overrun_pulse (overrun_pulse),
        .ch_sel        (ch_sel),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tvalid (m_axis_tvalid),
        .xfer          (xfer_if.seq),
        .tmr           (tmr_if.seq)
    );

    ads868x_timer timer_i (
        .s_axi_aclk (s_axi_aclk),
        .arst_n     (arst_n),
        .enable     (enable),
        .period     (period),
        .tmr        (tmr_if.tmr)
    );

    ads868x_spi spi_i (
        .s_axi_aclk (s_axi_aclk),
        .arst_n     (arst_n),
        .sck_div    (sck_div),
        .miso       (miso),
        .sck        (sck),
        .ss_n       (ss_n),
        .mosi       (mosi),
        .xfer       (xfer_if.spi)
    );

endmodule

`default_nettype wire

// ==== verif/ads868x_assert.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ads868x_defs.svh"

module ads868x_assert (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    tvalid,
    input  logic                    tready,
    input  logic [31:0]             tdata,
    input  logic                    sck,
    input  logic                    ss_n,
    input  logic                    start,
    input  logic                    xbusy,
    input  ads868x_pkg::seq_state_t state
);

    logic       sck_q;
    logic [6:0] sck_edges;

    // sck edges seen while chip select is low
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sck_q     <= 1'b0;
            sck_edges <= '0;
        end else begin
            sck_q <= sck;
            if (ss_n)
                sck_edges <= '0;
            else if (sck != sck_q)
                sck_edges <= sck_edges + 7'd1;
        end
    end

    // stalled stream word holds
    stream_hold: assert property (@(posedge clk) disable iff (!arst_n)
        tvalid && !tready |=> tvalid && $stable(tdata))
        else $error("stream word changed while stalled");

    // chip select rises only after every edge of the frame
    frame_select: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(ss_n) |-> sck_edges == 7'(2 * `ADS_FRAME_BITS))
        else $error("ss_n rose before the SPI frame completed");

    start_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !(start && xbusy))
        else $error("start issued while SPI engine busy");

    legal_state: assert property (@(posedge clk) disable iff (!arst_n)
        state <= ads868x_pkg::EMIT)
        else $error("sequencer in an illegal state");

endmodule

bind axi_ads868x ads868x_assert assert_i (
    .clk    (s_axi_aclk),
    .arst_n (arst_n),
    .tvalid (m_axis_tvalid),
    .tready (m_axis_tready),
    .tdata  (m_axis_tdata),
    .sck    (sck),
    .ss_n   (ss_n),
    .start  (xfer_if.start),
    .xbusy  (xfer_if.busy),
    .state  (seq_i.state)
);

`default_nettype wire

// ==== verif/tb_axi_ads868x.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ads868x_defs.svh"

module tb_axi_ads868x;

    localparam int ITERS      = 4;
    localparam int SCANS      = 2;
    localparam int MAX_DIV    = 3;
    localparam int TEST_PER   = 5000;
    localparam int OVR_PER    = 200;
    // worst-case clocks per channel, doubled for stream gaps
    localparam int CH_CLKS    = 2 * (2 * `ADS_FRAME_BITS * (MAX_DIV + 1)
                                + `ADS_SETTLE_CYCLES + 8);
    localparam longint WD_CLKS = 2 * (ITERS * (3 * TEST_PER + (SCANS + 2)
                                * (TEST_PER + `ADS_NUM_CH * CH_CLKS)) + 12 * OVR_PER
                                + 4 * `ADS_NUM_CH * CH_CLKS + 2000);

    logic        s_axi_aclk = 1'b0;
    logic        arst_n;
    logic [31:0] s_axi_awaddr, s_axi_wdata, s_axi_araddr;
    logic [3:0]  s_axi_wstrb;
    logic        s_axi_awvalid, s_axi_wvalid, s_axi_bready, s_axi_arvalid, s_axi_rready;
    logic        s_axi_awready, s_axi_wready, s_axi_bvalid, s_axi_arready, s_axi_rvalid;
    logic [1:0]  s_axi_bresp, s_axi_rresp;
    logic [31:0] s_axi_rdata, m_axis_tdata;
    logic        m_axis_tvalid, m_axis_tready;
    logic        sck, ss_n, mosi, miso, rst_pd_n;
    logic [2:0]  ch_sel;

    logic [31:0] rng_state = 32'd88;
    logic [15:0] adc_table [`ADS_NUM_CH];
    logic [31:0] exp_q [$];
    logic [7:0]  cur_mask;
    logic [31:0] adc_sh;
    logic        ss_prev, sck_prev;
    // 0 always ready, 1 random gaps, 2 held low
    int          tready_mode;
    bit          allow_words;
    int          word_cnt;
    int          checks;
    int          errors;

    axi_ads868x dut_i (.*);

    always #50 s_axi_aclk = !s_axi_aclk;

    function logic [31:0] xorshift();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error: %0t ns %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        @(negedge s_axi_aclk);
        s_axi_awaddr  = addr;
        s_axi_wdata   = data;
        s_axi_awvalid = 1'b1;
        s_axi_wvalid  = 1'b1;
        s_axi_bready  = 1'b1;
        do @(posedge s_axi_aclk); while (!s_axi_awready);
        @(negedge s_axi_aclk);
        s_axi_awvalid = 1'b0;
        s_axi_wvalid  = 1'b0;
        while (!s_axi_bvalid) @(posedge s_axi_aclk);
        resp = s_axi_bresp;
        @(negedge s_axi_aclk);
        s_axi_bready = 1'b0;
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        @(negedge s_axi_aclk);
        s_axi_araddr  = addr;
        s_axi_arvalid = 1'b1;
        s_axi_rready  = 1'b1;
        do @(posedge s_axi_aclk); while (!s_axi_arready);
        @(negedge s_axi_aclk);
        s_axi_arvalid = 1'b0;
        while (!s_axi_rvalid) @(posedge s_axi_aclk);
        data = s_axi_rdata;
        resp = s_axi_rresp;
        @(negedge s_axi_aclk);
        s_axi_rready = 1'b0;
    endtask

    // write, read back and compare against the register width
    task automatic write_check(input logic [31:0] addr, input logic [31:0] data,
                               input logic [31:0] mask);
        logic [31:0] rd;
        logic [1:0]  resp;
        write_reg(addr, data, resp);
        check("write resp", 32'(resp), 32'(ads868x_pkg::OKAY));
        read_reg(addr, rd, resp);
        check("read resp", 32'(resp), 32'(ads868x_pkg::OKAY));
        check("readback", rd, data & mask);
    endtask

    task automatic wait_idle();
        logic [31:0] rd;
        logic [1:0]  resp;
        do read_reg(32'(ads868x_pkg::STATUS), rd, resp); while (rd[0]);
    endtask

    // ADC model, one 16-bit sample per frame, MSB first
    always @(negedge s_axi_aclk) begin
        if (ss_prev && !ss_n) begin
            adc_sh = {adc_table[ch_sel], 16'd0};
            miso <= adc_sh[31];
        end else if (!ss_n && sck_prev && !sck) begin
            adc_sh = adc_sh << 1;
            miso <= adc_sh[31];
        end
        // command bits seen by the ADC on rising sck
        if (!ss_n && !sck_prev && sck)
            check("mosi command bit", 32'(mosi), 32'd0);
        ss_prev  = ss_n;
        sck_prev = sck;
    end

    always @(negedge s_axi_aclk) begin
        case (tready_mode)
            0:       m_axis_tready <= 1'b1;
            1:       m_axis_tready <= (xorshift() & 32'h3) != 32'h0;
            default: m_axis_tready <= 1'b0;
        endcase
    end

    // stream monitor, scans repeat the ascending channel list of the mask
    always @(posedge s_axi_aclk) begin
        if (arst_n && m_axis_tvalid && m_axis_tready) begin
            if (!allow_words) begin
                errors++;
                $display("stream word %h appeared while the scanner was disabled",
                         m_axis_tdata);
            end else begin
                if (exp_q.size() == 0) begin
                    for (int c = 0; c < `ADS_NUM_CH; c++) begin
                        if (cur_mask[c])
                            exp_q.push_back({13'd0, 3'(c), adc_table[c]});
                    end
                end
                check("stream word", m_axis_tdata, exp_q.pop_front());
            end
            word_cnt++;
        end
    end

    initial begin
        #(WD_CLKS * 100);
        $display("watchdog expired before the tests completed");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        logic [31:0] rd;
        logic [31:0] v;
        logic [1:0]  resp;
        int          pop;
        int          target;
        {s_axi_awaddr, s_axi_wdata, s_axi_araddr} = '0;
        s_axi_wstrb   = 4'hF;
        {s_axi_awvalid, s_axi_wvalid, s_axi_bready} = '0;
        {s_axi_arvalid, s_axi_rready} = '0;
        miso = 1'b0;
        ss_prev = 1'b1;
        sck_prev = 1'b0;
        cur_mask = '0;
        tready_mode = 0;
        allow_words = 1'b0;
        word_cnt = 0;
        checks = 0;
        errors = 0;
        for (int c = 0; c < `ADS_NUM_CH; c++)
            adc_table[c] = xorshift() >> 16;
        arst_n = 1'b0;
        repeat (10) @(negedge s_axi_aclk);
        arst_n = 1'b1;

        // register access
        read_reg(32'(ads868x_pkg::STATUS), rd, resp);
        check("status after reset", rd, 32'd0);
        v = xorshift();
        write_check(32'(ads868x_pkg::CTRL), v, 32'h3);
        check("rst_pd_n pin", 32'(rst_pd_n), 32'(v[1]));
        write_check(32'(ads868x_pkg::CTRL), 32'd0, 32'h3);
        write_check(32'(ads868x_pkg::CH_MASK), xorshift(), 32'hFF);
        write_check(32'(ads868x_pkg::PERIOD), xorshift(), 32'hFF_FFFF);
        write_check(32'(ads868x_pkg::SCK_DIV), xorshift(), 32'hFF);
        read_reg(32'h14, rd, resp);
        check("unmapped read resp", 32'(resp), 32'(ads868x_pkg::SLVERR));
        check("unmapped read data", rd, 32'd0);
        write_reg(32'h20, 32'hFFFF_FFFF, resp);
        check("unmapped write resp", 32'(resp), 32'(ads868x_pkg::SLVERR));
        read_reg(32'(ads868x_pkg::CTRL), rd, resp);
        check("ctrl after unmapped write", rd, 32'd0);

        // scan order, enable gating and back-pressure
        for (int it = 0; it < ITERS; it++) begin
            do cur_mask = xorshift() >> 24; while (cur_mask == 8'd0);
            for (int c = 0; c < `ADS_NUM_CH; c++)
                adc_table[c] = xorshift() >> 16;
            pop = $countones(cur_mask);
            write_check(32'(ads868x_pkg::CTRL), 32'h2, 32'h3);
            check("rst_pd_n pin", 32'(rst_pd_n), 32'd1);
            write_check(32'(ads868x_pkg::CH_MASK), {24'd0, cur_mask}, 32'hFF);
            write_check(32'(ads868x_pkg::SCK_DIV), xorshift() & 32'h3, 32'hFF);
            write_check(32'(ads868x_pkg::PERIOD), TEST_PER, 32'hFF_FFFF);
            repeat (3 * TEST_PER) @(negedge s_axi_aclk);
            allow_words = 1'b1;
            tready_mode = (it % 2 == 1) ? 1 : 0;
            target = word_cnt + SCANS * pop;
            write_check(32'(ads868x_pkg::CTRL), 32'h3, 32'h3);
            while (word_cnt < target) @(posedge s_axi_aclk);
            write_check(32'(ads868x_pkg::CTRL), 32'h2, 32'h3);
            wait_idle();
            tready_mode = 0;
            allow_words = 1'b0;
            check("words left in scan", 32'(exp_q.size()), 32'd0);
            read_reg(32'(ads868x_pkg::STATUS), rd, resp);
            check("conversion count", 32'(rd[31:16]), 32'(word_cnt[15:0]));
        end

        // overrun while the stream is stalled
        cur_mask = 8'hFF;
        allow_words = 1'b1;
        tready_mode = 2;
        write_check(32'(ads868x_pkg::CH_MASK), 32'hFF, 32'hFF);
        write_check(32'(ads868x_pkg::SCK_DIV), 32'd0, 32'hFF);
        write_check(32'(ads868x_pkg::PERIOD), OVR_PER, 32'hFF_FFFF);
        write_check(32'(ads868x_pkg::CTRL), 32'h3, 32'h3);
        repeat (6 * OVR_PER) @(negedge s_axi_aclk);
        read_reg(32'(ads868x_pkg::STATUS), rd, resp);
        check("overrun count non-zero", 32'(rd[15:8] != 8'd0), 32'd1);
        write_check(32'(ads868x_pkg::CTRL), 32'h2, 32'h3);
        tready_mode = 0;
        wait_idle();
        check("words left in scan", 32'(exp_q.size()), 32'd0);
        read_reg(32'(ads868x_pkg::STATUS), rd, resp);
        check("conversion count", 32'(rd[31:16]), 32'(word_cnt[15:0]));

        $display("checks %0d errors %0d words %0d", checks, errors, word_cnt);
        if (errors == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+common
common/ads868x_pkg.sv
common/ads868x_if.sv
verilog/ads868x_regs.sv
verilog/ads868x_seq.sv
verilog/ads868x_timer.sv
verilog/ads868x_spi.sv
verilog/axi_ads868x.sv
verif/ads868x_assert.sv
verif/tb_axi_ads868x.sv

// ==== run.sh ====
#!/bin/sh
# build and run the scanner testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f list.f \
    --top-module tb_axi_ads868x -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
grep -q "STATUS: PASS" sim.log
